// File: common/ldpc_in_pkg.sv
package ldpc_in_pkg;

  // --------------------
  // widths
  // --------------------

  localparam int cLLR_W  = 5;
  localparam int cROW_W  = 4; // 16 rows per column stride
  localparam int cCOL_W  = 3;
  localparam int cADDR_W = cCOL_W + cROW_W;

  typedef logic signed [cLLR_W-1 : 0] llr_t;
  typedef logic        [cROW_W-1 : 0] row_t;
  typedef logic        [cCOL_W-1 : 0] col_t;
  typedef logic       [cADDR_W-1 : 0] addr_t;
  typedef logic               [1 : 0] zc_idx_t;
  typedef logic               [4 : 0] zc_t;   // lifting size value
  typedef logic          [cCOL_W : 0] ncol_t; // column count, one bit wider than col_t

  // --------------------
  // code constants
  // --------------------

  // lifting sizes, index 0 is the smallest
  localparam zc_t [3 : 0] cZC_TAB = {5'd16, 5'd12, 5'd8, 5'd4};

  localparam int cNCOL = 1 << cCOL_W;

  // used columns, [0] long graph, [1] short graph
  localparam ncol_t [1 : 0] cGR_COLS = {ncol_t'(6), ncol_t'(8)};

  localparam int   cPUNCT_COLS = 2;  // leading columns never sent
  localparam llr_t cLLR_MAX    = 15;

  // --------------------
  // structs
  // --------------------

  typedef struct packed {
    zc_idx_t idx_zc;
    logic    idx_gr;
    logic    do_punct;
  } code_ctx_t;

  typedef struct packed {
    llr_t llr;
    logic hd;  // hard decision
  } buf_word_t;

  typedef struct packed {
    logic      we;
    addr_t     addr;
    buf_word_t dat;
  } buf_wr_t;

  typedef enum logic [1 : 0] {EMPTY, FILL, FULL} frame_state_t;

endpackage

// File: source/ldpc_in_source.sv
`timescale 1ns/1ps

module ldpc_in_source (
  input  logic                   iclk,
  input  logic                   ireset,
  //
  input  logic                   isop,
  input  logic                   ieop,
  input  logic                   ival,
  input  logic                   ien,     // frame ready level
  input  ldpc_in_pkg::llr_t      illr,
  input  ldpc_in_pkg::code_ctx_t icode_ctx,
  //
  output ldpc_in_pkg::buf_wr_t   owr,
  output logic                   oframe_start,
  output logic                   oframe_last
);

  logic                  acc;  // sample taken this cycle

  // context held from sop
  ldpc_in_pkg::row_t     used_zc_m1;
  ldpc_in_pkg::ncol_t    used_col_lim;

  // counters
  ldpc_in_pkg::row_t     row_cnt;
  logic                  row_done;  // row_cnt sits on last row
  ldpc_in_pkg::ncol_t    col_cnt;

  // address of the current sample
  ldpc_in_pkg::row_t     cur_row;
  ldpc_in_pkg::row_t     cur_zc_m1;
  ldpc_in_pkg::ncol_t    cur_col;
  ldpc_in_pkg::ncol_t    cur_lim;
  logic                  cur_done;
  logic                  cur_in;    // column inside graph

  ldpc_in_pkg::llr_t     llr_sat;
  logic                  llr_is_min;

  // write port regs
  logic                  wr_we;
  ldpc_in_pkg::addr_t    wr_addr;
  ldpc_in_pkg::buf_word_t wr_dat;

  assign acc = ival & ien;

  // --------------------
  // saturation + negation
  // --------------------

  assign llr_is_min = illr[ldpc_in_pkg::cLLR_W-1] & ~|illr[ldpc_in_pkg::cLLR_W-2 : 0];
  assign llr_sat    = llr_is_min ? ldpc_in_pkg::cLLR_MAX : -illr;  // -16 has no positive twin

  // --------------------
  // address select
  // --------------------

  always_comb begin
    if (isop) begin  // sop takes fresh context straight from the input
      cur_zc_m1 = ldpc_in_pkg::row_t'(ldpc_in_pkg::cZC_TAB[icode_ctx.idx_zc] - 1'b1);
      cur_lim   = ldpc_in_pkg::cGR_COLS[icode_ctx.idx_gr];
      cur_col   = icode_ctx.do_punct ? ldpc_in_pkg::ncol_t'(ldpc_in_pkg::cPUNCT_COLS) : '0;
      cur_row   = '0;
      cur_done  = (cur_zc_m1 == '0);
    end
    else begin
      cur_zc_m1 = used_zc_m1;
      cur_lim   = used_col_lim;
      cur_col   = col_cnt;
      cur_row   = row_cnt;
      cur_done  = row_done;
    end
    cur_in = (cur_col < cur_lim);
  end

  // --------------------
  // counters and strobes
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      used_zc_m1   <= '0;
      used_col_lim <= '0;  // nothing written before first sop
      row_cnt      <= '0;
      row_done     <= 1'b0;
      col_cnt      <= '0;
      wr_we        <= 1'b0;
      oframe_start <= 1'b0;
      oframe_last  <= 1'b0;
    end
    else begin
      wr_we        <= acc & cur_in;  // past the last column -> dropped
      oframe_start <= acc & isop;
      oframe_last  <= acc & ieop;
      if (acc) begin
        if (isop) begin
          used_zc_m1   <= cur_zc_m1;
          used_col_lim <= cur_lim;
        end
        if (cur_in) begin
          row_cnt  <= cur_done ? '0 : (cur_row + 1'b1);
          row_done <= cur_done ? (cur_zc_m1 == '0) : ((cur_row + 1'b1) == cur_zc_m1);
          col_cnt  <= cur_done ? (cur_col + 1'b1) : cur_col;  // next column on row wrap
        end
      end
    end
  end

  // payload
  always_ff @(posedge iclk) begin
    if (acc) begin
      wr_addr    <= {cur_col[ldpc_in_pkg::cCOL_W-1 : 0], cur_row};  // col * 16 + row
      wr_dat.llr <= llr_sat;
      wr_dat.hd  <= ~illr[ldpc_in_pkg::cLLR_W-1];  // input >= 0
    end
  end

  assign owr = '{we: wr_we, addr: wr_addr, dat: wr_dat};

endmodule

// File: source/ldpc_in_frame_ctrl.sv
`timescale 1ns/1ps

module ldpc_in_frame_ctrl (
  input  logic iclk,
  input  logic ireset,
  //
  input  logic isop_wr,      // sop written
  input  logic iframe_last,  // eop written
  input  logic irelease,     // decoder done with frame
  //
  output logic ordy,
  output logic obusy
);

  ldpc_in_pkg::frame_state_t state;
  ldpc_in_pkg::frame_state_t state_nxt;

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_nxt = state;
    unique case (state)
      ldpc_in_pkg::EMPTY : begin
        if (iframe_last) begin  // one sample frame
          state_nxt = ldpc_in_pkg::FULL;
        end
        else if (isop_wr) begin
          state_nxt = ldpc_in_pkg::FILL;
        end
      end
      ldpc_in_pkg::FILL : begin
        if (iframe_last) begin
          state_nxt = ldpc_in_pkg::FULL;
        end
      end
      ldpc_in_pkg::FULL : begin
        if (irelease) begin
          state_nxt = ldpc_in_pkg::EMPTY;
        end
      end
      default : state_nxt = ldpc_in_pkg::EMPTY;
    endcase
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= ldpc_in_pkg::EMPTY;
    end
    else begin
      state <= state_nxt;
    end
  end

  // --------------------
  // levels
  // --------------------

  // drop ready already in the eop write cycle, no sample slips behind eop
  assign ordy  = (state != ldpc_in_pkg::FULL) & ~iframe_last;
  assign obusy = (state != ldpc_in_pkg::EMPTY);

endmodule

// File: llr_mem/ldpc_in_arbiter.sv
`timescale 1ns/1ps

module ldpc_in_arbiter (
  input  logic                   iclk,
  input  logic                   ireset,
  //
  input  ldpc_in_pkg::buf_wr_t   iwr,      // source write
  input  logic                   irdreq,   // decoder read, held till ack
  input  ldpc_in_pkg::addr_t     irdaddr,
  output logic                   ordack,
  //
  output logic                   oram_en,
  output logic                   oram_we,
  output ldpc_in_pkg::addr_t     oram_addr,
  output ldpc_in_pkg::buf_word_t oram_wdat,
  //
  output logic                   ordval
);

  logic rd_grant;

  // --------------------
  // fixed priority
  // --------------------

  assign rd_grant  = irdreq & ~iwr.we;  // reads only fill idle port cycles

  assign oram_en   = iwr.we | irdreq;
  assign oram_we   = iwr.we;
  assign oram_addr = iwr.we ? iwr.addr : irdaddr;
  assign oram_wdat = iwr.dat;

  assign ordack    = rd_grant;

  // ram read is one cycle
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ordval <= 1'b0;
    end
    else begin
      ordval <= rd_grant;
    end
  end

endmodule

// File: llr_mem/ldpc_in_llr_ram.sv
`timescale 1ns/1ps

module ldpc_in_llr_ram (
  input  logic                   iclk,
  input  logic                   ireset,
  //
  input  logic                   iclear,  // new frame, drop all columns
  input  logic                   ien,
  input  logic                   iwe,
  input  ldpc_in_pkg::addr_t     iaddr,
  input  ldpc_in_pkg::buf_word_t iwdat,
  output ldpc_in_pkg::buf_word_t ordat
);

  ldpc_in_pkg::buf_word_t mem [2**ldpc_in_pkg::cADDR_W];

  logic [ldpc_in_pkg::cNCOL-1 : 0] col_valid;  // one bit per column
  ldpc_in_pkg::col_t               col;
  ldpc_in_pkg::buf_word_t          rd_q;

  assign col = iaddr[ldpc_in_pkg::cADDR_W-1 -: ldpc_in_pkg::cCOL_W];  // upper bits

  // --------------------
  // storage
  // --------------------

  always_ff @(posedge iclk) begin
    if (ien & iwe) begin
      mem[iaddr] <= iwdat;
    end
  end

  // --------------------
  // column valid bits
  // --------------------

  // write after clear in the same cycle keeps its column
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      col_valid <= '0;
    end
    else begin
      if (iclear) begin
        col_valid <= '0;
      end
      if (ien & iwe) begin
        col_valid[col] <= 1'b1;
      end
    end
  end

  // --------------------
  // registered read
  // --------------------

  // punctured or unwritten columns read as zero llr, hd 0
  always_ff @(posedge iclk) begin
    if (ien & ~iwe) begin
      rd_q <= col_valid[col] ? mem[iaddr] : '0;
    end
  end

  assign ordat = rd_q;

endmodule

// File: source/ldpc_in_top.sv
`timescale 1ns/1ps

module ldpc_in_top (
  input  logic                   iclk,
  input  logic                   ireset,
  // sample stream
  input  logic                   isop,
  input  logic                   ieop,
  input  logic                   ival,
  input  ldpc_in_pkg::llr_t      illr,
  input  ldpc_in_pkg::code_ctx_t icode_ctx,
  output logic                   ordy,
  output logic                   obusy,
  // decoder read side
  input  logic                   irdreq,
  input  ldpc_in_pkg::addr_t     irdaddr,
  output logic                   ordack,
  output logic                   ordval,
  output ldpc_in_pkg::buf_word_t ordata,
  input  logic                   irelease
);

  ldpc_in_pkg::buf_wr_t   src_wr;
  logic                   frame_start;
  logic                   frame_last;

  // single buffer port
  logic                   ram_en;
  logic                   ram_we;
  ldpc_in_pkg::addr_t     ram_addr;
  ldpc_in_pkg::buf_word_t ram_wdat;

  // --------------------
  // write side
  // --------------------

  ldpc_in_source i_source (
    .iclk         ( iclk        ),
    .ireset       ( ireset      ),
    .isop         ( isop        ),
    .ieop         ( ieop        ),
    .ival         ( ival        ),
    .ien          ( ordy        ),  // samples ignored while not ready
    .illr         ( illr        ),
    .icode_ctx    ( icode_ctx   ),
    .owr          ( src_wr      ),
    .oframe_start ( frame_start ),
    .oframe_last  ( frame_last  )
  );

  ldpc_in_frame_ctrl i_frame_ctrl (
    .iclk        ( iclk        ),
    .ireset      ( ireset      ),
    .isop_wr     ( frame_start ),
    .iframe_last ( frame_last  ),
    .irelease    ( irelease    ),
    .ordy        ( ordy        ),
    .obusy       ( obusy       )
  );

  // --------------------
  // buffer
  // --------------------

  ldpc_in_arbiter i_arbiter (
    .iclk      ( iclk     ),
    .ireset    ( ireset   ),
    .iwr       ( src_wr   ),
    .irdreq    ( irdreq   ),
    .irdaddr   ( irdaddr  ),
    .ordack    ( ordack   ),
    .oram_en   ( ram_en   ),
    .oram_we   ( ram_we   ),
    .oram_addr ( ram_addr ),
    .oram_wdat ( ram_wdat ),
    .ordval    ( ordval   )
  );

  ldpc_in_llr_ram i_llr_ram (
    .iclk   ( iclk        ),
    .ireset ( ireset      ),
    .iclear ( frame_start ),  // lands with the sop write
    .ien    ( ram_en      ),
    .iwe    ( ram_we      ),
    .iaddr  ( ram_addr    ),
    .iwdat  ( ram_wdat    ),
    .ordat  ( ordata      )
  );

endmodule

// File: verification/tb_ldpc_in.sv
`timescale 1ns/1ps

module tb_ldpc_in;

  localparam int cWAIT = 400;  // cycles allowed per wait loop

  logic                   iclk;
  logic                   ireset;
  logic                   isop;
  logic                   ieop;
  logic                   ival;
  ldpc_in_pkg::llr_t      illr;
  ldpc_in_pkg::code_ctx_t icode_ctx;
  logic                   ordy;
  logic                   obusy;
  logic                   irdreq;
  ldpc_in_pkg::addr_t     irdaddr;
  logic                   ordack;
  logic                   ordval;
  ldpc_in_pkg::buf_word_t ordata;
  logic                   irelease;

  ldpc_in_pkg::code_ctx_t frame_ctx;    // context of the frame in flight
  ldpc_in_pkg::llr_t      frame_llr[$];
  ldpc_in_pkg::buf_word_t exp_q[$];     // expected read words, grant order
  logic [31:0]            rng;
  int                     sent_cnt;     // samples taken so far
  logic                   sending;

  ldpc_in_top i_dut (.*);

  always #2 iclk = ~iclk;

  // --------------------
  // reference model
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int zc_of(input ldpc_in_pkg::zc_idx_t idx);
    return 4 * (int'(idx) + 1);  // 4, 8, 12, 16
  endfunction

  function automatic ldpc_in_pkg::buf_word_t expected_word(input ldpc_in_pkg::addr_t addr);
    int                     col;
    int                     row;
    int                     first;
    int                     lim;
    ldpc_in_pkg::llr_t      x;
    ldpc_in_pkg::buf_word_t w;
    col   = int'(addr[6:4]);  // stride of 16 rows
    row   = int'(addr[3:0]);
    first = frame_ctx.do_punct ? 2 : 0;
    lim   = frame_ctx.idx_gr ? 6 : 8;
    w     = '0;  // punctured or past the graph
    if (col >= first && col < lim && row < zc_of(frame_ctx.idx_zc)) begin
      x     = frame_llr[(col - first) * zc_of(frame_ctx.idx_zc) + row];
      w.llr = (x == ldpc_in_pkg::llr_t'(-16)) ? ldpc_in_pkg::llr_t'(15) : -x;
      w.hd  = (x >= 0);
    end
    return w;
  endfunction

  // --------------------
  // checks
  // --------------------

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  // read data lands one cycle after the grant
  always @(negedge iclk) begin : compare_reads
    ldpc_in_pkg::buf_word_t exp_w;
    if (ordval) begin
      if (exp_q.size() == 0) begin
        stop_run("read data came back without a granted request");
      end
      else begin
        exp_w = exp_q.pop_front();
        check_value("ordata", 32'(ordata), 32'(exp_w));
      end
    end
  end

  // --------------------
  // sample side
  // --------------------

  task automatic send_frame();
    int i;
    int guard;
    for (i = 0; i < frame_llr.size(); i++) begin
      isop      = (i == 0);
      ieop      = (i == frame_llr.size() - 1);
      ival      = 1'b1;
      illr      = frame_llr[i];
      icode_ctx = (i == 0) ? frame_ctx : ~frame_ctx;  // ctx only counts on sop
      guard     = 0;
      @(negedge iclk);
      if (i >= 2) check_value("obusy", 32'(obusy), 32'd1);
      while (!ordy && guard < cWAIT) begin
        guard++;
        @(negedge iclk);
      end
      if (!ordy) stop_run("sample never accepted, ordy stuck low");
      @(posedge iclk);  // taken at this edge
      #1;
      sent_cnt = i + 1;
      ival     = 1'b0;
      isop     = 1'b0;
      ieop     = 1'b0;
      rng      = xorshift32(rng);
      if (rng[1:0] == 2'b00 && i < frame_llr.size() - 1) begin  // idle slot for reads
        @(posedge iclk);
        #1;
      end
    end
    @(negedge iclk);
    check_value("ordy", 32'(ordy), 32'd0);  // already low in the eop write cycle
    @(posedge iclk);
    #1;
  endtask

  task automatic offer_while_full(input int cnt);
    int i;
    for (i = 0; i < cnt; i++) begin
      rng  = xorshift32(rng);
      isop = (i == 0);
      ival = 1'b1;
      illr = ldpc_in_pkg::llr_t'(rng[4:0]);
      @(negedge iclk);
      check_value("ordy", 32'(ordy), 32'd0);
      check_value("obusy", 32'(obusy), 32'd1);
      @(posedge iclk);
      #1;
    end
    isop = 1'b0;
    ival = 1'b0;
  endtask

  // --------------------
  // read side
  // --------------------

  task automatic read_word(input ldpc_in_pkg::addr_t addr);
    int guard;
    irdaddr = addr;
    irdreq  = 1'b1;  // held until ack
    guard   = 0;
    @(negedge iclk);
    while (!ordack && guard < cWAIT) begin  // writes win the port
      guard++;
      @(negedge iclk);
    end
    if (!ordack) stop_run("read request never acknowledged");
    exp_q.push_back(expected_word(addr));
    @(posedge iclk);
    #1;
    irdreq = 1'b0;
  endtask

  task automatic wait_reads_done();
    int guard;
    guard = 0;
    while (exp_q.size() != 0 && guard < cWAIT) begin
      guard++;
      @(posedge iclk);
      #1;
    end
    if (exp_q.size() != 0) stop_run("read data never returned");
  endtask

  // reads chase the write pointer while the frame fills
  task automatic trailing_reads();
    int zc;
    int first;
    int n_wr;
    int idx;
    int k;
    int guard;
    zc    = zc_of(frame_ctx.idx_zc);
    first = frame_ctx.do_punct ? 2 : 0;
    n_wr  = ((frame_ctx.idx_gr ? 6 : 8) - first) * zc;  // samples that reach the buffer
    k     = 0;
    guard = 0;
    while (sending && guard < 8 * cWAIT) begin  // each pass takes a cycle or more
      guard++;
      if (sent_cnt > 0) begin
        idx = (k % 2 == 0) ? sent_cnt - 1 : sent_cnt / 2;  // newest or older
        if (idx >= n_wr) idx = n_wr - 1;
        read_word(ldpc_in_pkg::addr_t'((first + idx / zc) * 16 + idx % zc));
        k++;
      end
      else begin
        @(posedge iclk);
        #1;
      end
    end
    if (sending) stop_run("sample stream never finished");
  endtask

  task automatic run_frame(input ldpc_in_pkg::code_ctx_t ctx, input int extra,
                           input logic ramp, input logic hold);
    int n;
    int i;
    int col;
    int row;
    frame_ctx = ctx;
    n = ((ctx.idx_gr ? 6 : 8) - (ctx.do_punct ? 2 : 0)) * zc_of(ctx.idx_zc) + extra;
    frame_llr.delete();
    for (i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      frame_llr.push_back(ramp ? ldpc_in_pkg::llr_t'(i - 16) : ldpc_in_pkg::llr_t'(rng[4:0]));
    end
    sent_cnt = 0;
    sending  = 1'b1;
    fork
      begin
        send_frame();
        sending = 1'b0;
      end
      trailing_reads();
    join
    wait_reads_done();
    if (hold) offer_while_full(6);  // must not touch the buffer
    for (col = 0; col < 8; col++) begin
      for (row = 0; row < zc_of(ctx.idx_zc); row++) begin
        read_word(ldpc_in_pkg::addr_t'(col * 16 + row));
      end
    end
    wait_reads_done();
    irelease = 1'b1;
    @(negedge iclk);
    check_value("ordy", 32'(ordy), 32'd0);  // still full during release
    @(posedge iclk);
    #1;
    irelease = 1'b0;
    @(negedge iclk);
    check_value("ordy", 32'(ordy), 32'd1);
    check_value("obusy", 32'(obusy), 32'd0);
    @(posedge iclk);
    #1;
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    int zi;
    iclk      = 1'b0;
    ireset    = 1'b1;
    isop      = 1'b0;
    ieop      = 1'b0;
    ival      = 1'b0;
    illr      = '0;
    icode_ctx = '0;
    irdreq    = 1'b0;
    irdaddr   = '0;
    irelease  = 1'b0;
    rng       = 32'hc3ce197a;
    sent_cnt  = 0;
    sending   = 1'b0;
    frame_ctx = '0;
    repeat (16) @(posedge iclk);
    #1;
    ireset = 1'b0;
    @(negedge iclk);
    check_value("ordy", 32'(ordy), 32'd1);
    check_value("obusy", 32'(obusy), 32'd0);
    check_value("ordack", 32'(ordack), 32'd0);
    check_value("ordval", 32'(ordval), 32'd0);
    check_value("src_wr.we", 32'(i_dut.src_wr.we), 32'd0);
    @(posedge iclk);
    #1;
    // -16..15 on zc 4, long graph, then junk while full
    run_frame(ldpc_in_pkg::code_ctx_t'({2'd0, 1'b0, 1'b0}), 0, 1'b1, 1'b1);
    for (zi = 0; zi < 8; zi++) begin  // every lifting size on both graphs
      run_frame(ldpc_in_pkg::code_ctx_t'({zi[2:1], zi[0], 1'b0}), 0, 1'b0, 1'b0);
    end
    // punctured, columns 0 and 1 still hold the last frame
    run_frame(ldpc_in_pkg::code_ctx_t'({2'd2, 1'b0, 1'b1}), 0, 1'b0, 1'b0);
    // short graph, samples past column 5 dropped
    run_frame(ldpc_in_pkg::code_ctx_t'({2'd1, 1'b1, 1'b0}), 20, 1'b0, 1'b0);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: ldpc_in.f
common/ldpc_in_pkg.sv
source/ldpc_in_source.sv
source/ldpc_in_frame_ctrl.sv
llr_mem/ldpc_in_arbiter.sv
llr_mem/ldpc_in_llr_ram.sv
source/ldpc_in_top.sv
verification/tb_ldpc_in.sv

// File: Makefile
TOP = tb_ldpc_in

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and search sim.log for the pass line"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f ldpc_in.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
